// ==== vcache_top.f ====
common/vcache_pkg.sv
rtl/vcache_decode.sv
vcache/vcache_core.sv
profiler/vcache_profiler.sv
rtl/vcache_top.sv
tests/vcache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module vcache_tb -f vcache_top.f -o vcache_sim
./obj_dir/vcache_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1

// ==== tests/vcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcache_tb;
  import vcache_pkg::*;

  localparam int sets_lp      = 16;
  localparam int idx_w_lp     = $clog2(sets_lp);
  localparam int tag_w_lp     = addr_width_lp - idx_w_lp;
  localparam int num_tests_lp = 6;

  typedef struct packed {
    logic                     wnr;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
  } pkt_s;

  logic            clk_i = 1'b0;
  logic            reset_i, req_v_i, req_ready_o, v_o, yumi_i;
  logic            dma_pkt_v_o, dma_pkt_yumi_i, dma_rdata_v_i, print_stat_v_i;
  vcache_opcode_e  req_op_i;
  logic [15:0]     req_addr_i;
  logic [31:0]     req_data_i, data_o, dma_wdata_o, dma_rdata_i, stat_o;
  logic [3:0]      req_mask_i;
  vcache_dma_pkt_s dma_pkt_o;
  vcache_stat_e    stat_sel_i;

  logic [31:0]         mem  [65536]; // backing memory
  logic [31:0]         smem [65536]; // what memory should hold
  logic [31:0]         sdata [sets_lp];
  logic [tag_w_lp-1:0] stag [sets_lp];
  logic [sets_lp-1:0]  svalid, sdirty;
  int                  exp_cnt [stat_num_lp];
  logic [31:0]         got_stat [stat_num_lp];
  logic [31:0]         prev_stat [stat_num_lp];
  logic [31:0]         exp_data [$];
  bit                  exp_care [$];
  pkt_s                exp_pkts [$];
  logic [31:0]         held_data, exp_word;
  bit                  held, exp_chk, bp_en, ready_fell;
  int                  errors, cyc, resp_cnt, strobe_cyc, strobe_resp, stretch;

  vcache_top #(.sets_p(sets_lp), .ctr_width_p(32)) dut0 (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] load_value(vcache_opcode_e op, logic [31:0] w,
                                             logic [3:0] mask);
    int          lane;
    logic [31:0] s;
    lane = 0;
    while (lane < 3 && !mask[lane]) lane++; // lowest enabled byte picks the lane
    s = w >> (8 * lane);
    case (op)
      e_op_lb:  return {{24{s[7]}}, s[7:0]};
      e_op_lbu: return {24'h0, s[7:0]};
      e_op_lh:  return {{16{s[15]}}, s[15:0]};
      e_op_lhu: return {16'h0, s[15:0]};
      default:  return w;
    endcase
  endfunction

  function automatic void write_back(logic [idx_w_lp-1:0] idx);
    exp_pkts.push_back(pkt_s'{1'b1, {stag[idx], idx}, sdata[idx]});
    smem[{stag[idx], idx}] = sdata[idx];
    sdirty[idx] = 1'b0;
    exp_cnt[e_stat_dma_write]++;
  endfunction

  // shadow cache: expected data, packets and counters for one request
  function automatic void predict(vcache_opcode_e op, logic [15:0] addr,
                                  logic [31:0] data, logic [3:0] mask);
    logic [idx_w_lp-1:0] idx;
    logic [tag_w_lp-1:0] tag;
    logic                hit;
    logic [31:0]         old, resp;
    idx  = addr[idx_w_lp-1:0];
    tag  = addr[15:idx_w_lp];
    hit  = svalid[idx] && (stag[idx] == tag);
    resp = 32'h0;
    if (!hit && !(op inside {e_op_tagst, e_op_afl, e_op_ainv})) begin
      if (svalid[idx] && sdirty[idx]) write_back(idx); // dirty victim first
      exp_pkts.push_back(pkt_s'{1'b0, addr, 32'h0});
      exp_cnt[e_stat_dma_read]++;
      sdata[idx]  = smem[addr];
      stag[idx]   = tag;
      svalid[idx] = 1'b1;
      sdirty[idx] = 1'b0;
    end
    old = sdata[idx];
    case (op)
      e_op_lb, e_op_lbu, e_op_lh, e_op_lhu, e_op_lw: begin
        resp = load_value(op, old, mask);
        if (!hit) begin
          exp_cnt[e_stat_miss_ld]++;
        end else begin
          exp_cnt[e_stat_ld]++;
          case (op)
            e_op_lb:  exp_cnt[e_stat_ld_lb]++;
            e_op_lbu: exp_cnt[e_stat_ld_lbu]++;
            e_op_lh:  exp_cnt[e_stat_ld_lh]++;
            e_op_lhu: exp_cnt[e_stat_ld_lhu]++;
            default:  exp_cnt[e_stat_ld_lw]++; // lw sign extends
          endcase
        end
      end
      e_op_sm: begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) sdata[idx][8*b +: 8] = data[8*b +: 8];
        end
        sdirty[idx] = 1'b1;
        if (!hit) begin
          exp_cnt[e_stat_miss_st]++;
        end else begin
          exp_cnt[e_stat_st]++;
          case ($countones(mask))
            4:       exp_cnt[e_stat_sm_sw]++;
            2:       exp_cnt[e_stat_sm_sh]++;
            1:       exp_cnt[e_stat_sm_sb]++;
            default: ;
          endcase
        end
      end
      e_op_amoswap, e_op_amoor: begin
        resp        = old;
        sdata[idx]  = (op == e_op_amoor) ? (old | data) : data;
        sdirty[idx] = 1'b1;
        exp_cnt[e_stat_atomic]++;
        exp_cnt[(op == e_op_amoor) ? e_stat_amoor : e_stat_amoswap]++;
      end
      e_op_tagst: begin
        stag[idx]   = tag;
        svalid[idx] = 1'b0;
        sdirty[idx] = 1'b0;
        exp_cnt[e_stat_tagst]++;
      end
      e_op_ainv: begin
        svalid[idx] = 1'b0; // dirty data is dropped
        exp_cnt[e_stat_ainv]++;
      end
      default: begin
        if (hit && sdirty[idx]) write_back(idx);
        exp_cnt[e_stat_afl]++;
      end
    endcase
    exp_data.push_back(resp);
    exp_care.push_back(op inside {e_op_lb, e_op_lbu, e_op_lh, e_op_lhu, e_op_lw,
                                  e_op_amoswap, e_op_amoor});
  endfunction

  // called on a falling edge, returns once the request is accepted
  task automatic issue(vcache_opcode_e op, logic [15:0] addr, logic [31:0] data,
                       logic [3:0] mask);
    predict(op, addr, data, mask);
    req_v_i    = 1'b1;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = data;
    req_mask_i = mask;
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_data.size() != 0 || exp_pkts.size() != 0) @(negedge clk_i);
  endtask

  task automatic strobe();
    print_stat_v_i = 1'b1;
    @(negedge clk_i);
    print_stat_v_i = 1'b0;
    strobe_cyc  = cyc;
    strobe_resp = resp_cnt;
  endtask

  task automatic read_stats();
    for (int i = 0; i < stat_num_lp; i++) begin
      stat_sel_i = vcache_stat_e'(i);
      @(negedge clk_i);
      got_stat[i] = stat_o;
    end
  endtask

  // cycle counters are checked in the snapshot test
  task automatic check_counts();
    strobe();
    read_stats();
    for (int i = 0; i < stat_num_lp; i++) begin
      if (i != e_stat_miss_cycles && i != e_stat_idle_cycles && got_stat[i] !== exp_cnt[i]) begin
        errors++;
        $display("Error: stat_o (stat_sel_i=%0d) got %h expected %h", i, got_stat[i], exp_cnt[i]);
      end
    end
  endtask

  // response monitor
  always @(posedge clk_i) begin
    cyc++;
    if (!reset_i) begin
      if (held && (!v_o || data_o !== held_data)) begin
        errors++;
        $display("Error: data_o under back-pressure got %h expected %h", data_o, held_data);
      end
      held      = v_o && !yumi_i;
      held_data = data_o;
      if (v_o && !yumi_i && !req_ready_o) ready_fell = 1'b1; // stalled behind a held response
      if (v_o && yumi_i) begin
        resp_cnt++;
        if (exp_data.size() == 0) begin
          errors++;
          $display("response arrived with no request outstanding");
        end else begin
          exp_word = exp_data.pop_front();
          exp_chk  = exp_care.pop_front();
          if (exp_chk && data_o !== exp_word) begin
            errors++;
            $display("Error: data_o got %h expected %h", data_o, exp_word);
          end
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (!bp_en) begin
      yumi_i = 1'b1;
    end else begin
      if (stretch == 0) begin
        yumi_i  = ~yumi_i;
        stretch = 1 + $urandom % 6;
      end
      stretch--;
    end
  end

  // memory model
  initial begin
    pkt_s got, want;
    forever begin
      @(negedge clk_i);
      if (!reset_i && dma_pkt_v_o) begin
        repeat ($urandom % 4) @(negedge clk_i);
        got = pkt_s'{dma_pkt_o.write_not_read, dma_pkt_o.addr,
                     dma_pkt_o.write_not_read ? dma_wdata_o : 32'h0};
        dma_pkt_yumi_i = 1'b1;
        @(negedge clk_i);
        dma_pkt_yumi_i = 1'b0;
        if (exp_pkts.size() == 0) begin
          errors++;
          $display("DMA packet to %h was not expected", got.addr);
        end else begin
          want = exp_pkts.pop_front();
          if (got !== want) begin
            errors++;
            $display("Error: dma_pkt_o got %h expected %h", got, want);
          end
        end
        if (got.wnr) begin
          mem[got.addr] = got.data;
        end else begin
          repeat (1 + $urandom % 4) @(negedge clk_i);
          dma_rdata_i   = mem[got.addr];
          dma_rdata_v_i = 1'b1;
          @(negedge clk_i);
          dma_rdata_v_i = 1'b0;
        end
      end
    end
  end

  task automatic test_loads();
    vcache_opcode_e ops [5] = '{e_op_lb, e_op_lbu, e_op_lh, e_op_lhu, e_op_lw};
    logic [3:0]     masks [5] = '{4'b0010, 4'b1000, 4'b1100, 4'b0011, 4'b1111};
    for (int i = 0; i < 5; i++) begin
      issue(ops[i], 16'h0100 + 16'(i), '0, masks[i]); // cold line
      issue(ops[i], 16'h0100 + 16'(i), '0, masks[i]); // now a hit
    end
    drain();
    check_counts();
  endtask

  task automatic test_stores();
    issue(e_op_lw, 16'h0105, '0, 4'hf);
    issue(e_op_sm, 16'h0105, 32'h11223344, 4'b0100);
    issue(e_op_lw, 16'h0105, '0, 4'hf);
    issue(e_op_sm, 16'h0105, 32'h55667788, 4'b0011);
    issue(e_op_lw, 16'h0105, '0, 4'hf);
    issue(e_op_sm, 16'h0105, 32'hcafef00d, 4'b1111);
    issue(e_op_lw, 16'h0105, '0, 4'hf);
    drain();
    check_counts();
  endtask

  task automatic test_conflict();
    issue(e_op_sm, 16'h0206, 32'ha5a5a5a5, 4'b1111);
    issue(e_op_lw, 16'h0216, '0, 4'hf); // same index, evicts the dirty line
    issue(e_op_lw, 16'h0206, '0, 4'hf); // refetch of the written-back word
    drain();
    check_counts();
  endtask

  task automatic test_line_ops();
    issue(e_op_amoswap, 16'h0307, 32'h0badcafe, 4'hf);
    issue(e_op_lw, 16'h0307, '0, 4'hf);
    issue(e_op_amoor, 16'h0307, 32'h00f000f0, 4'hf);
    issue(e_op_lw, 16'h0307, '0, 4'hf);
    issue(e_op_ainv, 16'h0307, '0, 4'hf);
    issue(e_op_lw, 16'h0307, '0, 4'hf);
    issue(e_op_sm, 16'h0307, 32'h12345678, 4'hf);
    issue(e_op_afl, 16'h0307, '0, 4'hf);
    issue(e_op_afl, 16'h0307, '0, 4'hf); // clean now, no write
    issue(e_op_tagst, 16'h0307, '0, 4'hf);
    issue(e_op_lw, 16'h0307, '0, 4'hf);
    drain();
    check_counts();
  endtask

  task automatic test_backpressure();
    logic [15:0] addr;
    bp_en      = 1'b1;
    ready_fell = 1'b0;
    repeat (24) begin
      addr = {4'h4 + 4'($urandom % 2), 8'h00, 4'h8 + 4'($urandom % 4)};
      case ($urandom % 3)
        0:       issue(e_op_lw, addr, '0, 4'hf);
        1:       issue(e_op_lbu, addr, '0, 4'b0100);
        default: issue(e_op_sm, addr, $urandom, 4'b0110);
      endcase
    end
    drain();
    bp_en = 1'b0;
    if (!ready_fell) begin
      errors++;
      $display("req_ready_o never fell while responses were held");
    end
    check_counts();
  endtask

  task automatic test_snapshot();
    int cyc0, resp0, sum;
    strobe();
    read_stats();
    prev_stat = got_stat;
    cyc0      = strobe_cyc;
    resp0     = strobe_resp;
    issue(e_op_lw, 16'h0500, '0, 4'hf);
    issue(e_op_sm, 16'h0500, 32'h01020304, 4'b1111);
    issue(e_op_lw, 16'h0610, '0, 4'hf);
    drain();
    read_stats();
    for (int i = 0; i < stat_num_lp; i++) begin
      if (got_stat[i] !== prev_stat[i]) begin
        errors++;
        $display("Error: stat_o (stat_sel_i=%0d) got %h expected %h", i, got_stat[i],
                 prev_stat[i]);
      end
    end
    check_counts();
    sum = got_stat[e_stat_miss_cycles] - prev_stat[e_stat_miss_cycles]
        + got_stat[e_stat_idle_cycles] - prev_stat[e_stat_idle_cycles]
        + strobe_resp - resp0;
    if (sum < strobe_cyc - cyc0) begin
      errors++;
      $display("cycle counters cover %0d of %0d cycles in the window", sum, strobe_cyc - cyc0);
    end
  endtask

  initial begin
    repeat (num_tests_lp * 2000) @(posedge clk_i);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(89482));
    for (int a = 0; a < 65536; a++) begin
      mem[a]  = $urandom;
      smem[a] = mem[a];
    end
    svalid         = '0;
    sdirty         = '0;
    reset_i        = 1'b1;
    req_v_i        = 1'b0;
    req_op_i       = e_op_lw;
    req_addr_i     = '0;
    req_data_i     = '0;
    req_mask_i     = '0;
    yumi_i         = 1'b1;
    dma_pkt_yumi_i = 1'b0;
    dma_rdata_v_i  = 1'b0;
    dma_rdata_i    = '0;
    print_stat_v_i = 1'b0;
    stat_sel_i     = e_stat_ld;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_loads();
    test_stores();
    test_conflict();
    test_line_ops();
    test_backpressure();
    test_snapshot();
    $display("responses: %0d  errors: %0d", resp_cnt, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/vcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcache_top #(
  parameter int sets_p      = 16,
  parameter int ctr_width_p = 32
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 req_v_i,
  input  vcache_pkg::vcache_opcode_e           req_op_i,
  input  logic [vcache_pkg::addr_width_lp-1:0] req_addr_i,
  input  logic [vcache_pkg::data_width_lp-1:0] req_data_i,
  input  logic [vcache_pkg::mask_width_lp-1:0] req_mask_i,
  output logic                                 req_ready_o,
  output logic                                 v_o,
  output logic [vcache_pkg::data_width_lp-1:0] data_o,
  input  logic                                 yumi_i,
  output vcache_pkg::vcache_dma_pkt_s          dma_pkt_o,
  output logic                                 dma_pkt_v_o,
  input  logic                                 dma_pkt_yumi_i,
  output logic [vcache_pkg::data_width_lp-1:0] dma_wdata_o,
  input  logic [vcache_pkg::data_width_lp-1:0] dma_rdata_i,
  input  logic                                 dma_rdata_v_i,
  input  logic                                 print_stat_v_i,
  input  vcache_pkg::vcache_stat_e             stat_sel_i,
  output logic [ctr_width_p-1:0]               stat_o
);
  import vcache_pkg::*;

  logic                     dec_v, dec_yumi, miss_v;
  vcache_decode_s           dec_decode, decode_v_r;
  logic [addr_width_lp-1:0] dec_addr;
  logic [data_width_lp-1:0] dec_data;
  logic [mask_width_lp-1:0] dec_mask, mask_v_r;

  vcache_decode decode0 (
    .clk_i, .reset_i,
    .req_v_i, .req_op_i, .req_addr_i, .req_data_i, .req_mask_i, .req_ready_o,
    .dec_v_o(dec_v), .dec_decode_o(dec_decode), .dec_addr_o(dec_addr),
    .dec_data_o(dec_data), .dec_mask_o(dec_mask), .dec_yumi_i(dec_yumi)
  );

  vcache_core #(.sets_p(sets_p)) core0 (
    .clk_i, .reset_i,
    .dec_v_i(dec_v), .dec_decode_i(dec_decode), .dec_addr_i(dec_addr),
    .dec_data_i(dec_data), .dec_mask_i(dec_mask), .dec_yumi_o(dec_yumi),
    .v_o, .data_o, .yumi_i,
    .miss_v_o(miss_v), .decode_v_r_o(decode_v_r), .mask_v_r_o(mask_v_r),
    .dma_pkt_o, .dma_pkt_v_o, .dma_pkt_yumi_i, .dma_wdata_o, .dma_rdata_i, .dma_rdata_v_i
  );

  vcache_profiler #(.ctr_width_p(ctr_width_p)) prof0 (
    .clk_i, .reset_i,
    .v_i(v_o), .yumi_i, .miss_v_i(miss_v),
    .decode_v_r_i(decode_v_r), .mask_v_r_i(mask_v_r),
    .dma_pkt_i(dma_pkt_o), .dma_pkt_v_i(dma_pkt_v_o), .dma_pkt_yumi_i,
    .print_stat_v_i, .stat_sel_i, .stat_o
  );

endmodule

`default_nettype wire

// ==== profiler/vcache_profiler.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcache_profiler #(
  parameter int ctr_width_p = 32
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 v_i,
  input  logic                                 yumi_i,
  input  logic                                 miss_v_i,
  input  vcache_pkg::vcache_decode_s           decode_v_r_i,
  input  logic [vcache_pkg::mask_width_lp-1:0] mask_v_r_i,
  input  vcache_pkg::vcache_dma_pkt_s          dma_pkt_i,
  input  logic                                 dma_pkt_v_i,
  input  logic                                 dma_pkt_yumi_i,
  input  logic                                 print_stat_v_i,
  input  vcache_pkg::vcache_stat_e             stat_sel_i,
  output logic [ctr_width_p-1:0]               stat_o
);
  import vcache_pkg::*;

  logic [stat_num_lp-1:0] inc;
  logic [ctr_width_p-1:0] ctr_r  [stat_num_lp];
  logic [ctr_width_p-1:0] ctr_n  [stat_num_lp];
  logic [ctr_width_p-1:0] snap_r [stat_num_lp];

  logic       resp, ld_hit, st_hit, dma_go;
  logic       size_b, size_h, size_w, sext;
  logic [2:0] mask_ones;

  assign resp      = v_i & yumi_i; // accepted response
  assign ld_hit    = resp & decode_v_r_i.ld_op & ~miss_v_i;
  assign st_hit    = resp & decode_v_r_i.st_op & ~miss_v_i;
  assign dma_go    = dma_pkt_v_i & dma_pkt_yumi_i;
  assign size_b    = (decode_v_r_i.data_size_op == 2'b00);
  assign size_h    = (decode_v_r_i.data_size_op == 2'b01);
  assign size_w    = (decode_v_r_i.data_size_op == 2'b10);
  assign sext      = decode_v_r_i.sigext_op;
  assign mask_ones = 3'($countones(mask_v_r_i));

  // event decode
  always_comb begin
    inc = '0;
    inc[e_stat_ld]      = ld_hit;
    inc[e_stat_ld_lw]   = ld_hit & size_w & sext;
    inc[e_stat_ld_lwu]  = ld_hit & size_w & ~sext;
    inc[e_stat_ld_lh]   = ld_hit & size_h & sext;
    inc[e_stat_ld_lhu]  = ld_hit & size_h & ~sext;
    inc[e_stat_ld_lb]   = ld_hit & size_b & sext;
    inc[e_stat_ld_lbu]  = ld_hit & size_b & ~sext;

    inc[e_stat_st]      = st_hit;
    inc[e_stat_sm_sw]   = st_hit & decode_v_r_i.mask_op & (mask_ones == 3'd4);
    inc[e_stat_sm_sh]   = st_hit & decode_v_r_i.mask_op & (mask_ones == 3'd2);
    inc[e_stat_sm_sb]   = st_hit & decode_v_r_i.mask_op & (mask_ones == 3'd1);

    inc[e_stat_tagst]   = resp & decode_v_r_i.tagst_op;
    inc[e_stat_afl]     = resp & decode_v_r_i.afl_op;
    inc[e_stat_ainv]    = resp & decode_v_r_i.ainv_op;
    inc[e_stat_atomic]  = resp & decode_v_r_i.atomic_op;
    inc[e_stat_amoswap] = inc[e_stat_atomic] & (decode_v_r_i.amo_subop == e_amo_swap);
    inc[e_stat_amoor]   = inc[e_stat_atomic] & (decode_v_r_i.amo_subop == e_amo_or);

    inc[e_stat_miss_ld]     = resp & decode_v_r_i.ld_op & miss_v_i;
    inc[e_stat_miss_st]     = resp & decode_v_r_i.st_op & miss_v_i;
    inc[e_stat_miss_cycles] = miss_v_i;
    inc[e_stat_idle_cycles] = ~resp & ~miss_v_i;

    inc[e_stat_dma_read]  = dma_go & ~dma_pkt_i.write_not_read;
    inc[e_stat_dma_write] = dma_go & dma_pkt_i.write_not_read;
  end

  // saturate instead of wrapping
  always_comb begin
    for (int i = 0; i < stat_num_lp; i++) begin
      if (inc[i] && (ctr_r[i] != '1)) begin
        ctr_n[i] = ctr_r[i] + 1'b1;
      end else begin
        ctr_n[i] = ctr_r[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < stat_num_lp; i++) begin
        ctr_r[i]  <= '0;
        snap_r[i] <= '0;
      end
    end else begin
      ctr_r <= ctr_n;
      if (print_stat_v_i) snap_r <= ctr_n; // includes this edge's events
    end
  end

  assign stat_o = (stat_sel_i < stat_num_lp) ? snap_r[stat_sel_i] : '0;

  // a counted load falls in exactly one size and sign bin
  ld_variant_a: assert property (@(posedge clk_i) disable iff (reset_i)
    inc[e_stat_ld] |-> $onehot(inc[e_stat_ld_lbu:e_stat_ld_lw]));

endmodule

`default_nettype wire

// ==== vcache/vcache_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcache_core #(
  parameter int sets_p = 16
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 dec_v_i,
  input  vcache_pkg::vcache_decode_s           dec_decode_i,
  input  logic [vcache_pkg::addr_width_lp-1:0] dec_addr_i,
  input  logic [vcache_pkg::data_width_lp-1:0] dec_data_i,
  input  logic [vcache_pkg::mask_width_lp-1:0] dec_mask_i,
  output logic                                 dec_yumi_o,
  output logic                                 v_o,
  output logic [vcache_pkg::data_width_lp-1:0] data_o,
  input  logic                                 yumi_i,
  output logic                                 miss_v_o,
  output vcache_pkg::vcache_decode_s           decode_v_r_o,
  output logic [vcache_pkg::mask_width_lp-1:0] mask_v_r_o,
  output vcache_pkg::vcache_dma_pkt_s          dma_pkt_o,
  output logic                                 dma_pkt_v_o,
  input  logic                                 dma_pkt_yumi_i,
  output logic [vcache_pkg::data_width_lp-1:0] dma_wdata_o,
  input  logic [vcache_pkg::data_width_lp-1:0] dma_rdata_i,
  input  logic                                 dma_rdata_v_i
);
  import vcache_pkg::*;

  localparam int idx_width_lp = $clog2(sets_p);
  localparam int tag_width_lp = addr_width_lp - idx_width_lp;

  typedef enum logic [2:0] {
    e_idle,
    e_lookup,
    e_evict,
    e_fill_req,
    e_fill_wait,
    e_resp
  } state_e;

  state_e state_r, state_n;

  vcache_decode_s           decode_r;
  logic [addr_width_lp-1:0] addr_r;
  logic [data_width_lp-1:0] wdata_r;
  logic [mask_width_lp-1:0] mask_r;
  logic [data_width_lp-1:0] resp_r;
  logic                     miss_r;

  logic [tag_width_lp-1:0]  tag_mem  [sets_p];
  logic [data_width_lp-1:0] data_mem [sets_p];
  logic [sets_p-1:0]        valid_r, dirty_r;

  logic [idx_width_lp-1:0]  idx;
  logic [tag_width_lp-1:0]  tag;
  logic [data_width_lp-1:0] old_word, shifted, ld_word, st_word, new_word;
  logic [1:0]               lane;
  logic                     hit, line_op, found_miss, done;

  assign idx        = addr_r[idx_width_lp-1:0];
  assign tag        = addr_r[addr_width_lp-1:idx_width_lp];
  assign old_word   = data_mem[idx];
  assign hit        = valid_r[idx] & (tag_mem[idx] == tag);
  assign line_op    = decode_r.ld_op | decode_r.st_op | decode_r.atomic_op;
  assign found_miss = (state_r == e_lookup) & line_op & ~hit;
  assign done       = (state_r == e_lookup) & ~found_miss; // op completes this cycle

  // load extraction, store merge and atomic result
  always_comb begin
    lane = 2'd0;
    for (int i = mask_width_lp - 1; i >= 0; i--) begin
      if (mask_r[i]) lane = 2'(i); // lowest enabled byte lane
    end
    shifted = old_word >> (8 * lane);
    case (decode_r.data_size_op)
      2'b00:   ld_word = {{24{decode_r.sigext_op & shifted[7]}}, shifted[7:0]};
      2'b01:   ld_word = {{16{decode_r.sigext_op & shifted[15]}}, shifted[15:0]};
      default: ld_word = old_word;
    endcase
    for (int b = 0; b < mask_width_lp; b++) begin
      st_word[8*b +: 8] = mask_r[b] ? wdata_r[8*b +: 8] : old_word[8*b +: 8];
    end
    if (!decode_r.atomic_op) begin
      new_word = st_word;
    end else if (decode_r.amo_subop == e_amo_or) begin
      new_word = old_word | wdata_r;
    end else begin
      new_word = wdata_r;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: if (dec_v_i) state_n = e_lookup;
      e_lookup: begin
        if (found_miss) begin
          state_n = (valid_r[idx] & dirty_r[idx]) ? e_evict : e_fill_req;
        end else if (decode_r.afl_op & hit & dirty_r[idx]) begin
          state_n = e_evict; // write back, then respond
        end else begin
          state_n = e_resp;
        end
      end
      e_evict:     if (dma_pkt_yumi_i) state_n = decode_r.afl_op ? e_resp : e_fill_req;
      e_fill_req:  if (dma_pkt_yumi_i) state_n = e_fill_wait;
      e_fill_wait: if (dma_rdata_v_i) state_n = e_lookup; // replay, now hits
      e_resp:      if (yumi_i) state_n = e_idle;
      default:     state_n = e_idle;
    endcase
  end

  assign dec_yumi_o   = (state_r == e_idle) & dec_v_i;
  assign v_o          = (state_r == e_resp);
  assign data_o       = resp_r;
  assign miss_v_o     = miss_r | found_miss;
  assign decode_v_r_o = decode_r;
  assign mask_v_r_o   = mask_r;

  assign dma_pkt_v_o              = (state_r == e_evict) | (state_r == e_fill_req);
  assign dma_pkt_o.write_not_read = (state_r == e_evict);
  assign dma_pkt_o.addr           = (state_r == e_evict) ? {tag_mem[idx], idx} : addr_r;
  assign dma_wdata_o              = old_word; // victim word

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      valid_r <= '0;
      dirty_r <= '0;
      miss_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      if (found_miss) begin
        miss_r <= 1'b1;
      end else if (v_o & yumi_i) begin
        miss_r <= 1'b0;
      end
      if (done & decode_r.tagst_op) begin
        valid_r[idx] <= 1'b0;
        dirty_r[idx] <= 1'b0;
      end
      if (done & decode_r.ainv_op) valid_r[idx] <= 1'b0;
      if (done & (decode_r.st_op | decode_r.atomic_op)) dirty_r[idx] <= 1'b1;
      if ((state_r == e_evict) & dma_pkt_yumi_i & decode_r.afl_op) dirty_r[idx] <= 1'b0;
      if ((state_r == e_fill_wait) & dma_rdata_v_i) begin
        valid_r[idx] <= 1'b1;
        dirty_r[idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_yumi_o) begin
      decode_r <= dec_decode_i;
      addr_r   <= dec_addr_i;
      wdata_r  <= dec_data_i;
      mask_r   <= dec_mask_i;
    end
    if (done) begin
      resp_r <= decode_r.ld_op ? ld_word : (decode_r.atomic_op ? old_word : '0);
      if (decode_r.st_op | decode_r.atomic_op) data_mem[idx] <= new_word;
      if (decode_r.tagst_op) tag_mem[idx] <= tag;
    end
    if ((state_r == e_fill_wait) & dma_rdata_v_i) begin
      data_mem[idx] <= dma_rdata_i;
      tag_mem[idx]  <= tag;
    end
  end

  dma_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_v_o & ~dma_pkt_yumi_i |=> dma_pkt_v_o & $stable(dma_pkt_o));

  resp_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o & ~yumi_i |=> v_o & $stable(data_o));

endmodule

`default_nettype wire

// ==== rtl/vcache_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcache_decode (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   req_v_i,
  input  vcache_pkg::vcache_opcode_e             req_op_i,
  input  logic [vcache_pkg::addr_width_lp-1:0]   req_addr_i,
  input  logic [vcache_pkg::data_width_lp-1:0]   req_data_i,
  input  logic [vcache_pkg::mask_width_lp-1:0]   req_mask_i,
  output logic                                   req_ready_o,
  output logic                                   dec_v_o,
  output vcache_pkg::vcache_decode_s             dec_decode_o,
  output logic [vcache_pkg::addr_width_lp-1:0]   dec_addr_o,
  output logic [vcache_pkg::data_width_lp-1:0]   dec_data_o,
  output logic [vcache_pkg::mask_width_lp-1:0]   dec_mask_o,
  input  logic                                   dec_yumi_i
);
  import vcache_pkg::*;

  logic           full_r;
  vcache_decode_s decode_n;
  logic           accept;

  assign req_ready_o = ~full_r | dec_yumi_i; // free, or emptied this cycle
  assign accept      = req_v_i & req_ready_o;
  assign dec_v_o     = full_r;

  always_comb begin
    decode_n           = '0;
    decode_n.ld_op     = req_op_i inside {e_op_lb, e_op_lbu, e_op_lh, e_op_lhu, e_op_lw};
    decode_n.st_op     = (req_op_i == e_op_sm);
    decode_n.atomic_op = req_op_i inside {e_op_amoswap, e_op_amoor};
    decode_n.mask_op   = decode_n.st_op | decode_n.atomic_op;
    decode_n.sigext_op = req_op_i inside {e_op_lb, e_op_lh, e_op_lw};
    decode_n.tagst_op  = (req_op_i == e_op_tagst);
    decode_n.afl_op    = (req_op_i == e_op_afl);
    decode_n.ainv_op   = (req_op_i == e_op_ainv);
    decode_n.amo_subop = (req_op_i == e_op_amoor) ? e_amo_or : e_amo_swap;
    case (req_op_i)
      e_op_lb, e_op_lbu: decode_n.data_size_op = 2'b00;
      e_op_lh, e_op_lhu: decode_n.data_size_op = 2'b01;
      default:           decode_n.data_size_op = 2'b10; // words, stores, atomics
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (accept) begin
      full_r <= 1'b1;
    end else if (dec_yumi_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_decode_o <= decode_n;
      dec_addr_o   <= req_addr_i;
      dec_data_o   <= req_data_i;
      dec_mask_o   <= req_mask_i;
    end
  end

  // a request the core has not taken must not change under it
  held_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    dec_v_o & ~dec_yumi_i |=> dec_v_o
      & $stable({dec_decode_o, dec_addr_o, dec_data_o, dec_mask_o}));

endmodule

`default_nettype wire

// ==== common/vcache_pkg.sv ====
`default_nettype none

package vcache_pkg;

  localparam int data_width_lp = 32;
  localparam int mask_width_lp = data_width_lp / 8;
  localparam int addr_width_lp = 16; // word address

  typedef enum logic [3:0] {
    e_op_lb,
    e_op_lbu,
    e_op_lh,
    e_op_lhu,
    e_op_lw,
    e_op_sm,
    e_op_tagst,
    e_op_afl,
    e_op_ainv,
    e_op_amoswap,
    e_op_amoor
  } vcache_opcode_e;

  typedef enum logic [0:0] {
    e_amo_swap,
    e_amo_or
  } vcache_amo_e;

  typedef struct packed {
    logic        ld_op;
    logic        st_op;
    logic        mask_op;
    logic        sigext_op;
    logic [1:0]  data_size_op; // 00 byte, 01 half, 10 word
    logic        tagst_op;
    logic        afl_op;
    logic        ainv_op;
    logic        atomic_op;
    vcache_amo_e amo_subop;
  } vcache_decode_s;

  typedef struct packed {
    logic                     write_not_read;
    logic [addr_width_lp-1:0] addr; // line address
  } vcache_dma_pkt_s;

  // one selector value per profiler counter
  typedef enum logic [4:0] {
    e_stat_ld,
    e_stat_ld_lw,
    e_stat_ld_lwu,
    e_stat_ld_lh,
    e_stat_ld_lhu,
    e_stat_ld_lb,
    e_stat_ld_lbu,
    e_stat_st,
    e_stat_sm_sw,
    e_stat_sm_sh,
    e_stat_sm_sb,
    e_stat_tagst,
    e_stat_afl,
    e_stat_ainv,
    e_stat_atomic,
    e_stat_amoswap,
    e_stat_amoor,
    e_stat_miss_ld,
    e_stat_miss_st,
    e_stat_miss_cycles,
    e_stat_idle_cycles,
    e_stat_dma_read,
    e_stat_dma_write
  } vcache_stat_e;

  localparam int stat_num_lp = 23;

endpackage

`default_nettype wire
